// File: Makefile
SRCS := $(shell cat udp_axi_bridge.f)
BIN  := obj_dir/Vtb_udp_axi_bridge

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) udp_axi_bridge.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_udp_axi_bridge -f udp_axi_bridge.f

run: $(BIN) udp_axi_bridge_trace.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: axi_bus_pkg.sv
`default_nettype none

package axi_bus_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = axi_data_w / 8;
    localparam int axi_id_w   = 2;
    localparam int axi_len_w  = 8;    // beats minus one

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10,
        burst_rsvd  = 2'b11
    } burst_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

endpackage

`default_nettype wire

// File: axi_wr_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_master (
    input  logic                               gmii_rx_clk,
    input  logic                               rstn,
    input  udp_cmd_pkg::wr_cmd_t               cmd,
    input  logic                               cmd_empty,
    output logic                               cmd_pop,
    input  udp_cmd_pkg::wr_beat_t              beat,
    input  logic                               beat_empty,
    output logic                               beat_pop,
    output logic [axi_bus_pkg::axi_id_w-1:0]   awid,
    output logic [axi_bus_pkg::axi_addr_w-1:0] awaddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]  awlen,
    output axi_bus_pkg::burst_t                awburst,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [axi_bus_pkg::axi_data_w-1:0] wdata,
    output logic [axi_bus_pkg::axi_strb_w-1:0] wstrb,
    output logic                               wlast,
    output logic                               wvalid,
    input  logic                               wready
);

    import udp_cmd_pkg::*;

    wr_cmd_t  aw_q;     // command on the AW channel
    wr_beat_t w_q;      // beat on the W channel
    logic     aw_load;
    logic     w_load;

    // each stage loads only while idle, so the FIFO head stays put until the handshake
    assign aw_load = !awvalid && !cmd_empty;
    assign w_load  = !wvalid && !beat_empty;

    assign cmd_pop  = awvalid && awready;
    assign beat_pop = wvalid && wready;

    assign awid    = aw_q.id;
    assign awaddr  = aw_q.addr;
    assign awlen   = aw_q.len;
    assign awburst = aw_q.burst;

    assign wdata = w_q.data;
    assign wlast = w_q.last;
    assign wstrb = '1;          // full words only

    always_ff @(posedge gmii_rx_clk) begin
        if (aw_load) begin
            aw_q <= cmd;
        end
        if (w_load) begin
            w_q <= beat;
        end
    end

    // write-address channel
    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            awvalid <= 1'b0;
        end else if (awvalid && awready) begin
            awvalid <= 1'b0;    // popped this cycle, next head seen after
        end else if (aw_load) begin
            awvalid <= 1'b1;
        end
    end

    // write-data channel, independent of AW
    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wvalid <= 1'b0;
        end else if (wvalid && wready) begin
            wvalid <= 1'b0;
        end else if (w_load) begin
            wvalid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 16
) (
    input  logic     gmii_rx_clk,
    input  logic     rstn,
    input  logic     push,
    input  payload_t wr_data,
    input  logic     pop,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;   // wrap for any depth
    endfunction

    assign do_push = push && !full;     // drop when full
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(depth));
    assign rd_data = mem[rd_ptr];       // head shows ahead of pop

    always_ff @(posedge gmii_rx_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // none, or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
) (
    output logic gmii_rx_clk,
    output logic rstn
);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #(period_ns / 2) gmii_rx_clk = ~gmii_rx_clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge gmii_rx_clk);
        #10 rstn = 1'b1;    // released off the edge, like the other inputs
    end

endmodule

`default_nettype wire

// File: tb_udp_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_axi_bridge;

    import axi_bus_pkg::*;

    logic        gmii_rx_clk, rstn;
    logic        udp_rx_en, udp_rx_done;
    logic [31:0] udp_rx_data;
    logic [1:0]  awid, bid;
    logic [31:0] awaddr, wdata, udp_tx_data;
    logic [7:0]  awlen;
    burst_t      awburst;
    resp_t       bresp;
    logic [3:0]  wstrb;
    logic [15:0] udp_tx_byte_num;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic        udp_tx_start, udp_tx_req, udp_tx_done;

    logic [31:0] trace [0:511];
    logic [43:0] exp_aw [$];    // id, burst, len, addr
    logic [32:0] exp_w [$];     // last, data
    logic [1:0]  resp_q [$];
    logic [1:0]  aw_ids [$];
    logic [31:0] exp_rep [$];
    int          trace_len = 0;
    int          bursts_done = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    integer      seed = 32'h6ae5a387;
    logic        aw_pend = 1'b0, w_pend = 1'b0, tx_busy = 1'b0;
    logic [43:0] ea;
    logic [32:0] ew;
    logic [31:0] er;

    tb_clk_gen #(.period_ns(100), .reset_cycles(3)) u_clk (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn)
    );

    udp_axi_bridge dut (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn),
        .udp_rx_en (udp_rx_en), .udp_rx_done (udp_rx_done), .udp_rx_data (udp_rx_data),
        .awid (awid), .awaddr (awaddr), .awlen (awlen), .awburst (awburst),
        .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
        .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .udp_tx_start (udp_tx_start), .udp_tx_byte_num (udp_tx_byte_num),
        .udp_tx_req (udp_tx_req), .udp_tx_data (udp_tx_data), .udp_tx_done (udp_tx_done)
    );

    // AXI slave: random ready on AW and W
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        forever begin
            @(posedge gmii_rx_clk);
            #10;
            {wready, awready} = 2'($random(seed));
        end
    end

    // AW and W monitor
    always @(posedge gmii_rx_clk) begin
        if (aw_pend) begin
            checks++;
            assert (awvalid) else begin
                $display("awvalid dropped before its handshake");
                errors++;
            end
        end
        if (w_pend) begin
            checks++;
            assert (wvalid) else begin
                $display("wvalid dropped before its handshake");
                errors++;
            end
        end
        aw_pend = awvalid && !awready;
        w_pend  = wvalid && !wready;
        if (awvalid && awready) begin
            assert (exp_aw.size() > 0) else begin
                $display("unexpected write command on AW, address %h", awaddr);
                errors++;
            end
            if (exp_aw.size() > 0) begin
                ea = exp_aw.pop_front();
                checks++;
                assert ({awid, 2'(awburst), awlen, awaddr} == ea) else begin
                    $display("[FAIL] awid/awburst/awlen/awaddr: expected %h got %h",
                             ea, {awid, 2'(awburst), awlen, awaddr});
                    errors++;
                end
            end
            aw_ids.push_back(awid);
        end
        if (wvalid && wready) begin
            assert (exp_w.size() > 0) else begin
                $display("unexpected write beat on W, data %h", wdata);
                errors++;
            end
            if (exp_w.size() > 0) begin
                ew = exp_w.pop_front();
                checks++;
                assert (wdata == ew[31:0]) else begin
                    $display("[FAIL] wdata: expected %h got %h", ew[31:0], wdata);
                    errors++;
                end
                assert (wlast == ew[32]) else begin
                    $display("[FAIL] wlast: expected %h got %h", ew[32], wlast);
                    errors++;
                end
                assert (wstrb == 4'hf) else begin
                    $display("[FAIL] wstrb: expected %h got %h", 4'hf, wstrb);
                    errors++;
                end
            end
            if (wlast) bursts_done++;
        end
    end

    // B responder, AXI order: n-th finished burst gets the n-th awid
    initial begin
        bvalid = 1'b0;
        bid    = '0;
        bresp  = resp_okay;
        forever begin
            @(posedge gmii_rx_clk);
            if (!bvalid || bready) begin
                #10;
                if (bursts_done > 0 && aw_ids.size() > 0 && resp_q.size() > 0) begin
                    bursts_done--;
                    bid    = aw_ids.pop_front();
                    bresp  = resp_t'(resp_q.pop_front());
                    bvalid = 1'b1;
                    exp_rep.push_back({8'hff, 6'b0, bid, 6'b0, 2'(bresp), 8'h00});
                end else begin
                    bvalid = 1'b0;
                end
            end
        end
    end

    // UDP transmitter, slow on purpose so reports pile up
    initial begin
        udp_tx_req  = 1'b0;
        udp_tx_done = 1'b0;
        forever begin
            @(posedge gmii_rx_clk);
            if (udp_tx_start) begin
                tx_busy = 1'b1;
                checks++;
                assert (udp_tx_byte_num == 16'd4) else begin
                    $display("[FAIL] udp_tx_byte_num: expected %h got %h", 16'd4,
                             udp_tx_byte_num);
                    errors++;
                end
                repeat (6) @(posedge gmii_rx_clk);
                #10 udp_tx_req = 1'b1;
                @(posedge gmii_rx_clk);
                assert (exp_rep.size() > 0) else begin
                    $display("report sent with no write response behind it");
                    errors++;
                end
                if (exp_rep.size() > 0) begin
                    er = exp_rep.pop_front();
                    checks++;
                    assert (udp_tx_data == er) else begin
                        $display("[FAIL] udp_tx_data: expected %h got %h", er, udp_tx_data);
                        errors++;
                    end
                end
                #10;
                udp_tx_req  = 1'b0;
                udp_tx_done = 1'b1;
                @(posedge gmii_rx_clk);
                #10 udp_tx_done = 1'b0;
                tx_busy = 1'b0;
            end
        end
    end

    task automatic send_packet(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge gmii_rx_clk);
            #10;
            udp_rx_en   = 1'b1;
            udp_rx_data = trace[base + i];
            udp_rx_done = (i == n - 1);
        end
        @(posedge gmii_rx_clk);
        #10;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_aw.size() > 0 || exp_w.size() > 0 || resp_q.size() > 0 ||
               exp_rep.size() > 0 || bvalid || tx_busy) begin
            @(posedge gmii_rx_clk);
        end
        repeat (4) @(posedge gmii_rx_clk);  // catch stray handshakes
    endtask

    // watchdog, 200 cycles per trace word
    initial begin
        wait (trace_len != 0);
        repeat (trace_len * 200) @(posedge gmii_rx_clk);
        $display("timeout, the DUT stopped answering before the trace ended");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int pc;
        int n;
        int test_errors;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        $readmemh("udp_axi_bridge_trace.txt", trace);
        pc = 0;
        while (trace[pc] !== 32'hf000_0000 && pc < 511) pc++;
        trace_len = pc + 1;
        wait (rstn);
        @(posedge gmii_rx_clk);
        checks++;
        assert (!awvalid && !wvalid && !bready && !udp_tx_start && udp_tx_byte_num == 0)
        else begin
            $display("outputs not idle after reset");
            errors++;
        end
        test_errors = errors;
        pc = 0;
        while (trace[pc] !== 32'hf000_0000) begin
            n = int'(trace[pc][15:0]);
            case (trace[pc][31:28])
                4'h1: begin
                    send_packet(pc + 1, n);
                    pc += n + 1;
                end
                4'h2: begin
                    for (int i = 0; i < n; i++) begin
                        exp_aw.push_back({trace[pc + 1 + 2 * i][17:16],
                                          trace[pc + 1 + 2 * i][13:12],
                                          trace[pc + 1 + 2 * i][7:0], trace[pc + 2 + 2 * i]});
                    end
                    pc += 2 * n + 1;
                end
                4'h3: begin
                    for (int i = 0; i < n; i++) begin
                        exp_w.push_back({i == n - 1, trace[pc + 1 + i]});
                    end
                    pc += n + 1;
                end
                4'h4: begin
                    for (int i = 0; i < n; i++) resp_q.push_back(trace[pc + 1 + i][1:0]);
                    pc += n + 1;
                end
                4'he: begin
                    wait_drained();
                    tests++;
                    $display("test %0d %s, %0d errors", tests,
                             (errors == test_errors) ? "passed" : "failed",
                             errors - test_errors);
                    test_errors = errors;
                    pc += 1;
                end
                default: begin
                    $display("bad trace record %h at word %0d", trace[pc], pc);
                    errors++;
                    pc += 1;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_axi_bridge.f
axi_bus_pkg.sv
udp_cmd_pkg.sv
sync_fifo.sv
udp_cmd_parser.sv
axi_wr_master.sv
wr_resp_reporter.sv
udp_axi_bridge.sv
tb_clk_gen.sv
tb_udp_axi_bridge.sv

// File: udp_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module udp_axi_bridge (
    input  logic                               gmii_rx_clk,
    input  logic                               rstn,
    input  logic                               udp_rx_en,
    input  logic                               udp_rx_done,
    input  logic [axi_bus_pkg::axi_data_w-1:0] udp_rx_data,
    output logic [axi_bus_pkg::axi_id_w-1:0]   awid,
    output logic [axi_bus_pkg::axi_addr_w-1:0] awaddr,
    output logic [axi_bus_pkg::axi_len_w-1:0]  awlen,
    output axi_bus_pkg::burst_t                awburst,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [axi_bus_pkg::axi_data_w-1:0] wdata,
    output logic [axi_bus_pkg::axi_strb_w-1:0] wstrb,
    output logic                               wlast,
    output logic                               wvalid,
    input  logic                               wready,
    input  logic [axi_bus_pkg::axi_id_w-1:0]   bid,
    input  axi_bus_pkg::resp_t                 bresp,
    input  logic                               bvalid,
    output logic                               bready,
    output logic                               udp_tx_start,
    output logic [15:0]                        udp_tx_byte_num,
    input  logic                               udp_tx_req,
    output logic [31:0]                        udp_tx_data,
    input  logic                               udp_tx_done
);

    import udp_cmd_pkg::*;

    logic     cmd_push;
    wr_cmd_t  cmd_in;
    logic     cmd_pop;
    wr_cmd_t  cmd_head;
    logic     cmd_empty;
    logic     beat_push;
    wr_beat_t beat_in;
    logic     beat_pop;
    wr_beat_t beat_head;
    logic     beat_empty;

    udp_cmd_parser u_parser (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .udp_rx_en   (udp_rx_en),
        .udp_rx_done (udp_rx_done),
        .udp_rx_data (udp_rx_data),
        .cmd_push    (cmd_push),
        .cmd         (cmd_in),
        .beat_push   (beat_push),
        .beat        (beat_in)
    );

    sync_fifo #(.payload_t(wr_cmd_t), .depth(cmd_fifo_depth)) u_cmd_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (cmd_push),
        .wr_data     (cmd_in),
        .pop         (cmd_pop),
        .rd_data     (cmd_head),
        .empty       (cmd_empty),
        .full        ()
    );

    sync_fifo #(.payload_t(wr_beat_t), .depth(beat_fifo_depth)) u_beat_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (beat_push),
        .wr_data     (beat_in),
        .pop         (beat_pop),
        .rd_data     (beat_head),
        .empty       (beat_empty),
        .full        ()
    );

    axi_wr_master u_master (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .cmd         (cmd_head),
        .cmd_empty   (cmd_empty),
        .cmd_pop     (cmd_pop),
        .beat        (beat_head),
        .beat_empty  (beat_empty),
        .beat_pop    (beat_pop),
        .awid        (awid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awburst     (awburst),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready)
    );

    wr_resp_reporter u_reporter (
        .gmii_rx_clk     (gmii_rx_clk),
        .rstn            (rstn),
        .bid             (bid),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .udp_tx_start    (udp_tx_start),
        .udp_tx_byte_num (udp_tx_byte_num),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_data     (udp_tx_data),
        .udp_tx_done     (udp_tx_done)
    );

endmodule

`default_nettype wire

// File: udp_axi_bridge_trace.txt
// 1000_000N packet of N words | 2000_000N N AW pairs (000I_B0LL, addr) | 3000_000N burst data
// 4000_000N bresp codes | E0000000 end of test | F0000000 end of trace
// test 1: one write command, 4-beat burst
20000001 00011003 10000040
30000004 0BEA0000 0BEA0001 0BEA0002 0BEA0003
40000001 00000000
10000002 00510300 10000040
10000005 FF000000 0BEA0000 0BEA0001 0BEA0002 0BEA0003
E0000000
// test 2: three writes around a read, then an unknown tag
20000003 00021000 20000000 00030000 20000200 00002000 20000300
30000001 AAAA0001
30000001 AAAA0002
30000001 AAAA0003
40000003 00000001 00000002 00000000
10000008 00610000 20000000 00500000 20000100 00310000 20000200 00810000 20000300
10000002 5A000000 12345678
10000002 FF000000 AAAA0001
10000002 FF000000 AAAA0002
10000002 FF000000 AAAA0003
E0000000
// test 3: 8-beat burst
20000001 00011007 30000000
30000008 C0DE0000 C0DE0001 C0DE0002 C0DE0003 C0DE0004 C0DE0005 C0DE0006 C0DE0007
40000001 00000002
10000002 00510700 30000000
10000009 FF000000 C0DE0000 C0DE0001 C0DE0002 C0DE0003 C0DE0004 C0DE0005 C0DE0006 C0DE0007
E0000000
// test 4: two bursts under back-pressure
20000002 00021004 40000000 00001004 40001000
30000005 11110000 11110001 11110002 11110003 11110004
30000005 22220000 22220001 22220002 22220003 22220004
40000002 00000003 00000000
10000004 00610400 40000000 00410400 40001000
10000006 FF000000 11110000 11110001 11110002 11110003 11110004
10000006 FF000000 22220000 22220001 22220002 22220003 22220004
E0000000
// test 5: four single beats, reports queue behind the slow transmitter
20000004 00001000 50000000 00011000 50000004 00021000 50000008 00031000 5000000C
30000001 D0000000
30000001 D0000001
30000001 D0000002
30000001 D0000003
40000004 00000000 00000001 00000002 00000003
10000008 00410000 50000000 00510000 50000004 00610000 50000008 00710000 5000000C
10000002 FF000000 D0000000
10000002 FF000000 D0000001
10000002 FF000000 D0000002
10000002 FF000000 D0000003
E0000000
F0000000

// File: udp_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cmd_parser (
    input  logic                               gmii_rx_clk,
    input  logic                               rstn,
    input  logic                               udp_rx_en,
    input  logic                               udp_rx_done,
    input  logic [axi_bus_pkg::axi_data_w-1:0] udp_rx_data,
    output logic                               cmd_push,
    output udp_cmd_pkg::wr_cmd_t               cmd,
    output logic                               beat_push,
    output udp_cmd_pkg::wr_beat_t              beat
);

    import axi_bus_pkg::*;
    import udp_cmd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr_first,
        st_addr_second,
        st_data
    } state_t;

    state_t                state;
    logic [axi_data_w-1:0] first_word;      // packet header or first command word
    logic                  first_is_write;
    logic                  keep_beats;

    assign first_is_write = (first_word[tag_lsb +: 8] == tag_addr_pkt) &&
                            first_word[wr_flag_bit];

    // unknown tags also pass through st_data, but nothing is forwarded
    assign keep_beats = (first_word[tag_lsb +: 8] == tag_data_pkt);

    assign beat_push = (state == st_data) && keep_beats && udp_rx_en;
    assign beat      = '{last: udp_rx_done, data: udp_rx_data};

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && (state == st_idle || state == st_addr_first)) begin
            first_word <= udp_rx_data;
        end
        if (udp_rx_en && state == st_addr_second) begin
            cmd.id    <= first_word[id_lsb +: axi_id_w];
            cmd.burst <= burst_t'(first_word[burst_lsb +: 2]);
            cmd.len   <= first_word[len_lsb +: axi_len_w];
            cmd.addr  <= udp_rx_data;       // second word is the address
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            cmd_push <= 1'b0;
        end else begin
            cmd_push <= 1'b0;
            if (udp_rx_en) begin
                case (state)
                    st_idle: begin
                        if (!udp_rx_done) begin
                            if (udp_rx_data[tag_lsb +: 8] == tag_addr_pkt) begin
                                state <= st_addr_second;
                            end else begin
                                state <= st_data;
                            end
                        end
                    end
                    st_addr_first: begin
                        state <= udp_rx_done ? st_idle : st_addr_second;
                    end
                    st_addr_second: begin
                        cmd_push <= first_is_write;     // read commands go nowhere
                        state    <= udp_rx_done ? st_idle : st_addr_first;
                    end
                    st_data: begin
                        if (udp_rx_done) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: udp_cmd_pkg.sv
`default_nettype none

package udp_cmd_pkg;

    localparam logic [7:0] tag_addr_pkt  = 8'h00;
    localparam logic [7:0] tag_data_pkt  = 8'hFF;
    localparam logic [7:0] tag_wr_report = 8'hFF;

    // bit positions inside the first word of a command
    localparam int tag_lsb     = 24;
    localparam int burst_lsb   = 22;
    localparam int id_lsb      = 20;
    localparam int wr_flag_bit = 16;
    localparam int len_lsb     = 8;

    typedef struct packed {
        logic [axi_bus_pkg::axi_id_w-1:0]   id;
        axi_bus_pkg::burst_t                burst;
        logic [axi_bus_pkg::axi_len_w-1:0]  len;
        logic [axi_bus_pkg::axi_addr_w-1:0] addr;
    } wr_cmd_t;

    typedef struct packed {
        logic                               last;
        logic [axi_bus_pkg::axi_data_w-1:0] data;
    } wr_beat_t;

    typedef struct packed {
        logic [7:0]                       tag;
        logic [5:0]                       zero_hi;
        logic [axi_bus_pkg::axi_id_w-1:0] id;
        logic [5:0]                       zero_lo;
        axi_bus_pkg::resp_t               resp;
        logic [7:0]                       zero_byte;
    } report_word_t;

    localparam int cmd_fifo_depth    = 16;
    localparam int beat_fifo_depth   = 256;
    localparam int report_fifo_depth = 16;

    localparam logic [15:0] report_bytes = 16'd4;   // one report word per send

endpackage

`default_nettype wire

// File: wr_resp_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module wr_resp_reporter (
    input  logic                             gmii_rx_clk,
    input  logic                             rstn,
    input  logic [axi_bus_pkg::axi_id_w-1:0] bid,
    input  axi_bus_pkg::resp_t               bresp,
    input  logic                             bvalid,
    output logic                             bready,
    output logic                             udp_tx_start,
    output logic [15:0]                      udp_tx_byte_num,
    input  logic                             udp_tx_req,
    output logic [31:0]                      udp_tx_data,
    input  logic                             udp_tx_done
);

    import udp_cmd_pkg::*;

    typedef enum logic {
        tx_idle,
        tx_sending
    } tx_state_t;

    tx_state_t    tx_state;
    logic         resp_en;      // low through reset, then stays high
    logic         rep_push;
    report_word_t rep_word;
    logic         rep_pop;
    report_word_t rep_head;
    logic         rep_empty;
    logic         rep_full;

    assign bready      = resp_en && !rep_full;
    assign rep_pop     = (tx_state == tx_sending) && udp_tx_req;
    assign udp_tx_data = rep_head;

    always_ff @(posedge gmii_rx_clk) begin
        if (bvalid && bready) begin
            rep_word <= '{tag: tag_wr_report, zero_hi: '0, id: bid,
                          zero_lo: '0, resp: bresp, zero_byte: '0};
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            resp_en  <= 1'b0;
            rep_push <= 1'b0;
        end else begin
            resp_en  <= 1'b1;
            rep_push <= bvalid && bready;   // report lands one cycle after accept
        end
    end

    sync_fifo #(
        .payload_t (report_word_t),
        .depth     (report_fifo_depth)
    ) u_report_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (rep_push),
        .wr_data     (rep_word),
        .pop         (rep_pop),
        .rd_data     (rep_head),
        .empty       (rep_empty),
        .full        (rep_full)
    );

    // one report per UDP send
    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            tx_state        <= tx_idle;
            udp_tx_start    <= 1'b0;
            udp_tx_byte_num <= '0;
        end else begin
            udp_tx_start <= 1'b0;
            case (tx_state)
                tx_idle: begin
                    if (!rep_empty) begin
                        udp_tx_start    <= 1'b1;
                        udp_tx_byte_num <= report_bytes;
                        tx_state        <= tx_sending;
                    end
                end
                tx_sending: begin
                    if (udp_tx_done) begin
                        tx_state <= tx_idle;
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire
